// ==== source/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

//////////////////////////////
// Bank geometry
//////////////////////////////

// Word address bits decoded inside one bank
// Upper CPU address bits above these alias
`define RAM_ADDR_BITS 8

//////////////////////////////
// Bank timing
//////////////////////////////

// Cycles from a seen start to the edge that raises done
// Must be at least 1
`define RAM_WAIT_CYCLES 3

`endif

// ==== source/mem_pkg.sv ====
`include "mem_defines.svh"

package mem_pkg;

	// Basic widths
	typedef logic [15:0] mem_word_t;
	typedef logic [15:0] mem_addr_t;
	typedef logic [15:0] mem_tag_t;
	typedef logic [`RAM_ADDR_BITS-1:0] bank_addr_t;

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_t;

	// CPU request, 49 bits
	typedef struct packed {
		mem_op_t   op;
		mem_addr_t addr;
		mem_word_t wdata;
		mem_tag_t  tag;
	} mem_req_t;

	// CPU response, 33 bits
	typedef struct packed {
		mem_op_t   op;
		mem_word_t rdata;
		mem_tag_t  tag;
	} mem_rsp_t;

	// Controller to bank
	typedef struct packed {
		mem_op_t    op;
		bank_addr_t addr;
		mem_word_t  wdata;
	} bank_cmd_t;

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_ISSUE,
		CTRL_WAIT,
		CTRL_RESPOND
	} ctrl_state_t;

	typedef enum logic [1:0] {
		BANK_IDLE,
		BANK_BUSY,
		BANK_DONE
	} bank_state_t;

endpackage

// ==== source/ram_bank.sv ====
`timescale 1ns/1ns

`include "mem_defines.svh"

module ram_bank (
	input  logic                ram_work_done,
	input  logic                rst_n,

	input  mem_pkg::bank_cmd_t  cmd,
	input  logic                start,
	output logic                done,
	output mem_pkg::mem_word_t  rdata
);

	import mem_pkg::*;

	localparam int DEPTH = 1 << `RAM_ADDR_BITS;
	// One extra value so a single-cycle wait still gets a counter bit
	localparam int CNT_W = $clog2(`RAM_WAIT_CYCLES + 1);

	bank_state_t      state;
	logic [CNT_W-1:0] wait_cnt;
	bank_cmd_t        cmd_q;
	logic             take_cmd;
	logic             access_now;

	mem_word_t        mem_array [0:DEPTH-1];

	//////////////////////////////
	// Access sequencer
	//////////////////////////////

	assign take_cmd   = start && (state == BANK_IDLE);
	// Last edge of the wait, the array is touched here
	assign access_now = (state == BANK_BUSY) && (wait_cnt == '0);

	always_ff @(posedge ram_work_done or negedge rst_n) begin
		if (!rst_n) begin
			state    <= BANK_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				BANK_IDLE: begin
					if (take_cmd) begin
						state    <= BANK_BUSY;
						wait_cnt <= CNT_W'(`RAM_WAIT_CYCLES - 1);
					end
				end
				BANK_BUSY: begin
					if (access_now) begin
						state <= BANK_DONE;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				// Done lasts exactly one cycle
				BANK_DONE: begin
					state <= BANK_IDLE;
				end
				default: begin
					state <= BANK_IDLE;
				end
			endcase
		end
	end

	assign done = (state == BANK_DONE);

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge ram_work_done) begin
		if (take_cmd) begin
			cmd_q <= cmd;
		end
	end

	// Write returns the word it just stored
	always_ff @(posedge ram_work_done) begin
		if (access_now) begin
			if (cmd_q.op == MEM_WRITE) begin
				mem_array[cmd_q.addr] <= cmd_q.wdata;
				rdata                 <= cmd_q.wdata;
			end else begin
				rdata <= mem_array[cmd_q.addr];
			end
		end
	end

endmodule

// ==== source/ram_controller.sv ====
`timescale 1ns/1ns

`include "mem_defines.svh"

module ram_controller (
	input  logic                ram_work_done,
	input  logic                rst_n,

	// CPU request channel
	input  mem_pkg::mem_req_t   req,
	input  logic                req_valid,
	output logic                req_ready,

	// CPU response channel
	output mem_pkg::mem_rsp_t   rsp,
	output logic                rsp_valid,
	input  logic                rsp_ready,

	// Bank 1, selected when address bit 15 is set
	output mem_pkg::bank_cmd_t  ram1_cmd,
	output logic                ram1_start,
	input  logic                ram1_done,
	input  mem_pkg::mem_word_t  ram1_rdata,

	// Bank 2, selected when address bit 15 is clear
	output mem_pkg::bank_cmd_t  ram2_cmd,
	output logic                ram2_start,
	input  logic                ram2_done,
	input  mem_pkg::mem_word_t  ram2_rdata
);

	import mem_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;

	mem_req_t    req_q;
	logic        sel_ram1;

	logic        accept;
	logic        rsp_fire;
	logic        bank_done;
	mem_word_t   bank_rdata;
	bank_cmd_t   bank_cmd;

	//////////////////////////////
	// Handshakes
	//////////////////////////////

	assign req_ready = (state == CTRL_IDLE);
	assign rsp_valid = (state == CTRL_RESPOND);

	assign accept   = req_valid && req_ready;
	assign rsp_fire = rsp_valid && rsp_ready;

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			CTRL_IDLE: begin
				if (accept) begin
					state_next = CTRL_ISSUE;
				end
			end
			// Start is high for this single cycle only
			CTRL_ISSUE: begin
				state_next = CTRL_WAIT;
			end
			CTRL_WAIT: begin
				if (bank_done) begin
					state_next = CTRL_RESPOND;
				end
			end
			// Held here under back-pressure
			CTRL_RESPOND: begin
				if (rsp_fire) begin
					state_next = CTRL_IDLE;
				end
			end
			default: begin
				state_next = CTRL_IDLE;
			end
		endcase
	end

	always_ff @(posedge ram_work_done or negedge rst_n) begin
		if (!rst_n) begin
			state    <= CTRL_IDLE;
			sel_ram1 <= 1'b0;
		end else begin
			state <= state_next;
			if (accept) begin
				sel_ram1 <= req.addr[15];
			end
		end
	end

	// Accepted request, tag included, kept until the response is taken
	always_ff @(posedge ram_work_done) begin
		if (accept) begin
			req_q <= req;
		end
	end

	//////////////////////////////
	// Bank side
	//////////////////////////////

	// Both banks see the same command, only the start picks one
	assign bank_cmd.op    = req_q.op;
	assign bank_cmd.addr  = req_q.addr[`RAM_ADDR_BITS-1:0];
	assign bank_cmd.wdata = req_q.wdata;

	assign ram1_cmd = bank_cmd;
	assign ram2_cmd = bank_cmd;

	assign ram1_start = (state == CTRL_ISSUE) && sel_ram1;
	assign ram2_start = (state == CTRL_ISSUE) && !sel_ram1;

	// The other bank's done is ignored
	assign bank_done  = sel_ram1 ? ram1_done : ram2_done;
	assign bank_rdata = sel_ram1 ? ram1_rdata : ram2_rdata;

	//////////////////////////////
	// Response
	//////////////////////////////

	// Captured once on done, stable through the RESPOND state
	always_ff @(posedge ram_work_done) begin
		if (state == CTRL_WAIT && bank_done) begin
			rsp.op    <= req_q.op;
			rsp.rdata <= bank_rdata;
			rsp.tag   <= req_q.tag;
		end
	end

endmodule

// ==== source/memory_subsystem.sv ====
`timescale 1ns/1ns

module memory_subsystem (
	input  logic               ram_work_done,
	input  logic               rst_n,

	input  mem_pkg::mem_req_t  req,
	input  logic               req_valid,
	output logic               req_ready,

	output mem_pkg::mem_rsp_t  rsp,
	output logic               rsp_valid,
	input  logic               rsp_ready
);

	import mem_pkg::*;

	bank_cmd_t ram1_cmd;
	logic      ram1_start;
	logic      ram1_done;
	mem_word_t ram1_rdata;

	bank_cmd_t ram2_cmd;
	logic      ram2_start;
	logic      ram2_done;
	mem_word_t ram2_rdata;

	//////////////////////////////
	// Routing controller
	//////////////////////////////

	ram_controller u_ctrl (
		.ram_work_done (ram_work_done),
		.rst_n         (rst_n),
		.req           (req),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.rsp           (rsp),
		.rsp_valid     (rsp_valid),
		.rsp_ready     (rsp_ready),
		.ram1_cmd      (ram1_cmd),
		.ram1_start    (ram1_start),
		.ram1_done     (ram1_done),
		.ram1_rdata    (ram1_rdata),
		.ram2_cmd      (ram2_cmd),
		.ram2_start    (ram2_start),
		.ram2_done     (ram2_done),
		.ram2_rdata    (ram2_rdata)
	);

	//////////////////////////////
	// Banks
	//////////////////////////////

	// Upper half of the address space
	ram_bank u_ram1 (
		.ram_work_done (ram_work_done),
		.rst_n         (rst_n),
		.cmd           (ram1_cmd),
		.start         (ram1_start),
		.done          (ram1_done),
		.rdata         (ram1_rdata)
	);

	// Lower half of the address space
	ram_bank u_ram2 (
		.ram_work_done (ram_work_done),
		.rst_n         (rst_n),
		.cmd           (ram2_cmd),
		.start         (ram2_start),
		.done          (ram2_done),
		.rdata         (ram2_rdata)
	);

endmodule

// ==== verification/memory_subsystem_tb.sv ====
`timescale 1ns/1ns

`include "mem_defines.svh"

module memory_subsystem_tb;

	import mem_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 5;
	localparam int MAX_REQ      = 64;
	localparam int REC_WORDS    = 6;
	localparam int MAX_GAP      = 3;
	localparam int TAIL_CYCLES  = 8;

	logic        ram_work_done;
	logic        rst_n;
	mem_req_t    req;
	logic        req_valid;
	logic        req_ready;
	mem_rsp_t    rsp;
	logic        rsp_valid;
	logic        rsp_ready;

	// One record is op, addr, wdata, tag, stall, expected rdata
	logic [15:0] stim_mem [0:MAX_REQ*REC_WORDS-1];
	int          num_req = 0;
	int          max_stall = 0;
	int          watchdog_cycles = 0;
	logic        stim_loaded = 1'b0;
	integer      seed = 32'hd5268b7e;

	int          mismatch_errors = 0;
	int          protocol_errors = 0;
	int          rsp_count = 0;
	logic        pending = 1'b0;
	logic        held = 1'b0;
	mem_rsp_t    held_rsp;
	mem_addr_t   accepted_addr;

	memory_subsystem dut (
		.ram_work_done (ram_work_done),
		.rst_n         (rst_n),
		.req           (req),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.rsp           (rsp),
		.rsp_valid     (rsp_valid),
		.rsp_ready     (rsp_ready)
	);

	initial begin
		ram_work_done = 1'b0;
		forever #(CLK_PERIOD/2) ram_work_done = ~ram_work_done;
	end

	//////////////////////////////
	// Stimulus records
	//////////////////////////////

	function automatic logic [15:0] stim_field(input int i, input int k);
		return stim_mem[i*REC_WORDS+k];
	endfunction

	function automatic mem_req_t request_of(input int i);
		mem_req_t    r;
		logic [15:0] op_word;
		op_word = stim_field(i, 0);
		r.op    = mem_op_t'(op_word[0]);
		r.addr  = stim_field(i, 1);
		r.wdata = stim_field(i, 2);
		r.tag   = stim_field(i, 3);
		return r;
	endfunction

	function automatic mem_rsp_t expected_rsp(input int i);
		mem_rsp_t    r;
		logic [15:0] op_word;
		op_word = stim_field(i, 0);
		r.op    = mem_op_t'(op_word[0]);
		r.rdata = stim_field(i, 5);
		r.tag   = stim_field(i, 3);
		return r;
	endfunction

	task automatic load_stimulus();
		int i;
		int stall;
		// Op slot above 1 marks the end of the records
		for (i = 0; i < MAX_REQ*REC_WORDS; i++) begin
			stim_mem[i] = 16'h8000 | 16'(i);
		end
		$readmemh("verification/mem_stim.txt", stim_mem);
		while (num_req < MAX_REQ && stim_field(num_req, 0) <= 16'd1) begin
			stall = 32'(stim_field(num_req, 4));
			if (stall > max_stall) begin
				max_stall = stall;
			end
			num_req++;
		end
		if (num_req == 0) begin
			protocol_errors++;
			$display("The stimulus file held no requests");
		end
		stim_loaded = 1'b1;
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic check_rsp(input int idx, input mem_rsp_t got, input mem_rsp_t exp);
		if (got.op !== exp.op || got.rdata !== exp.rdata || got.tag !== exp.tag) begin
			mismatch_errors++;
			$display("mismatch at %0t ns: response %0d got %s %h tag %h, expected %s %h tag %h",
				$time, idx, got.op.name(), got.rdata, got.tag,
				exp.op.name(), exp.rdata, exp.tag);
		end
	endtask

	task automatic check_handshake(input logic ok, input string what);
		if (ok !== 1'b1) begin
			protocol_errors++;
			$display("Protocol error at %0t ns: %s", $time, what);
		end
	endtask

	// Inputs change on the falling edge, so the rising edge sees them settled
	always @(posedge ram_work_done) begin
		if (rst_n === 1'b1) begin
			if (held) begin
				check_handshake(rsp_valid === 1'b1 && rsp === held_rsp,
					"an outstanding response changed before it was taken");
			end
			if (rsp_valid === 1'b1) begin
				check_handshake(pending, "a response appeared with no request outstanding");
			end
			// Address bit 15 set goes to bank 1, clear goes to bank 2
			if (dut.ram1_start === 1'b1 || dut.ram2_start === 1'b1) begin
				check_handshake(dut.ram1_start === accepted_addr[15]
					&& dut.ram2_start === !accepted_addr[15],
					"a request was sent to the wrong bank");
			end
			if (req_valid === 1'b1 && req_ready === 1'b1) begin
				check_handshake(!pending, "a request was accepted while a response was pending");
				pending       = 1'b1;
				accepted_addr = req.addr;
			end
			if (rsp_valid === 1'b1 && rsp_ready === 1'b1) begin
				rsp_count++;
				pending = 1'b0;
			end
			held     = (rsp_valid === 1'b1) && (rsp_ready !== 1'b1);
			held_rsp = rsp;
		end
	end

	//////////////////////////////
	// Request and response sides
	//////////////////////////////

	task automatic drive_requests();
		int i;
		int gap;
		for (i = 0; i < num_req; i++) begin
			gap = {$random(seed)} % (MAX_GAP + 1);
			repeat (gap) @(negedge ram_work_done);
			req       = request_of(i);
			req_valid = 1'b1;
			while (req_ready !== 1'b1) @(negedge ram_work_done);
			@(negedge ram_work_done);
			req_valid = 1'b0;
			req       = '0;
		end
	endtask

	task automatic take_responses();
		int i;
		int k;
		for (i = 0; i < num_req; i++) begin
			while (rsp_valid !== 1'b1) @(negedge ram_work_done);
			check_rsp(i, rsp, expected_rsp(i));
			// Back-pressure, controller must not take a new request
			for (k = 0; k < 32'(stim_field(i, 4)); k++) begin
				@(negedge ram_work_done);
				check_handshake(req_ready === 1'b0, "req_ready high while a response was held");
			end
			rsp_ready = 1'b1;
			@(negedge ram_work_done);
			rsp_ready = 1'b0;
		end
	endtask

	initial begin
		watchdog_cycles = 0;
		wait (stim_loaded === 1'b1);
		watchdog_cycles = num_req * (`RAM_WAIT_CYCLES + 4 + max_stall)
			+ num_req * MAX_GAP + RESET_CYCLES + TAIL_CYCLES + 20;
		#(watchdog_cycles * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles with %0d of %0d responses received",
			watchdog_cycles, rsp_count, num_req);
		$display("Errors: %0d mismatch, %0d protocol", mismatch_errors, protocol_errors);
		$display("Test failed");
		$finish;
	end

	initial begin
		rst_n     = 1'b0;
		req       = '0;
		req_valid = 1'b0;
		rsp_ready = 1'b0;
		load_stimulus();

		repeat (RESET_CYCLES) @(negedge ram_work_done);
		check_handshake(rsp_valid === 1'b0, "rsp_valid high during reset");
		rst_n = 1'b1;
		@(negedge ram_work_done);
		check_handshake(req_ready === 1'b1, "req_ready low after reset");
		check_handshake(rsp_valid === 1'b0, "rsp_valid high after reset");

		fork
			drive_requests();
			take_responses();
		join

		// Nothing more may come back
		repeat (TAIL_CYCLES) begin
			@(negedge ram_work_done);
			check_handshake(rsp_valid === 1'b0, "an extra response appeared after the last one");
		end
		check_handshake(rsp_count == num_req,
			$sformatf("received %0d responses for %0d requests", rsp_count, num_req));

		$display("Errors: %0d mismatch, %0d protocol; %0d of %0d responses",
			mismatch_errors, protocol_errors, rsp_count, num_req);
		if (mismatch_errors == 0 && protocol_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== verification/mem_stim.txt ====
// Columns: op (0 read, 1 write), addr, wdata, tag, stall cycles, expected rdata
// All values hex, one request per line

// Bank 1, address bit 15 set
1 8010 1234 0100 0 1234
1 8011 abcd 0104 2 abcd
1 80ff 5a5a 0108 0 5a5a
0 8010 dead 010c 0 1234
0 8011 0000 0110 3 abcd
0 80ff 0000 0114 1 5a5a

// Bank 2, address bit 15 clear
1 0010 4321 0118 0 4321
1 0022 beef 011c 1 beef
1 00ff 0f0f 0120 0 0f0f
0 0010 0000 0124 2 4321
0 0022 ffff 0128 0 beef
0 00ff 0000 012c 0 0f0f

// Same low address in both banks
1 8040 aaaa 0130 0 aaaa
1 0040 5555 0134 0 5555
0 8040 0000 0138 0 aaaa
0 0040 0000 013c 4 5555

// Bits 14 to 8 alias inside a bank
0 ff40 0000 0140 0 aaaa
0 7f40 0000 0144 1 5555

// Overwrite and cross checks
1 8010 c3c3 0148 5 c3c3
0 8010 0000 014c 0 c3c3
0 0010 0000 0150 0 4321
1 7fff ffff 0154 2 ffff
0 00ff 0000 0158 0 ffff
0 80ff 0000 015c 0 5a5a

// ==== sim.f ====
+incdir+source
source/mem_pkg.sv
source/ram_bank.sv
source/ram_controller.sv
source/memory_subsystem.sv
verification/memory_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=memory_subsystem_tb
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found on PATH"
	exit 1
fi

rm -f "$LOG"

verilator --binary --timing -j 0 \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR" \
	-o "V$TOP" \
	-f sim.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test passed" "$LOG"; then
	echo "Simulation run OK"
	exit 0
fi

echo "Pass line not found in $LOG"
exit 1
